// ==== hdl/mult_config.svh ====
`ifndef MULT_CONFIG_SVH
`define MULT_CONFIG_SVH

// operand width, must be even and >= 4
`define MULT_WIDTH 32

// testbench defaults
`define MULT_CLK_PERIOD 8
`define MULT_RST_CYCLES 4
`define MULT_NUM_RANDOM 200
`define MULT_SEED       83066
`define MULT_DRIVE_SKEW 1

`endif

// ==== hdl/mult_pkg.sv ====
package mult_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,  // waiting for start
        LOAD  = 3'd1,  // operands into the datapath
        ADD   = 3'd2,  // booth add/sub on upper half
        SHIFT = 3'd3,  // arithmetic shift right by one
        DONE  = 3'd4   // result valid, one cycle
    } mult_state_e;

    // operation on the upper product half during ADD
    typedef enum logic [1:0] {
        ALU_NONE = 2'd0,
        ALU_ADD  = 2'd1,  // pair 01, end of a run of ones
        ALU_SUB  = 2'd2   // pair 10, start of a run of ones
    } alu_op_e;

endpackage : mult_pkg

// ==== hdl/mult_ctrl_if.sv ====
`timescale 1ns/1ps

interface mult_ctrl_if
    import mult_pkg::*;
();

    logic       load;      // capture operands, clear upper half
    logic       add_en;    // write alu result into upper half
    alu_op_e    alu_op;
    logic       shift_en;  // arithmetic shift of whole product

    // {product lsb, extra bit}
    logic [1:0] booth_pair;

    modport ctrl (
        output load,
        output add_en,
        output alu_op,
        output shift_en,
        input  booth_pair
    );

    modport dp (
        input  load,
        input  add_en,
        input  alu_op,
        input  shift_en,
        output booth_pair
    );

endinterface : mult_ctrl_if

// ==== hdl/booth_datapath.sv ====
`timescale 1ns/1ps

`include "mult_config.svh"

module booth_datapath
    import mult_pkg::*;
#(
    parameter int WIDTH = `MULT_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic signed [WIDTH-1:0]   a,
    input  logic signed [WIDTH-1:0]   b,
    output logic signed [2*WIDTH-1:0] p,
    mult_ctrl_if.dp                   ctrl
);

    // Upper half carries one guard bit. Subtracting the most negative
    // multiplicand from zero needs WIDTH+1 bits, otherwise
    // min*min comes out negative.
    localparam int PROD_W = 2 * WIDTH + 1;

    logic signed [WIDTH-1:0]  mcand;
    logic signed [PROD_W-1:0] prod;   // {guard, upper, lower}
    logic                     extra_bit;

    logic signed [WIDTH:0]    upper;
    logic signed [WIDTH:0]    mcand_ext;
    logic signed [WIDTH:0]    alu_res;

    assign upper     = prod[PROD_W-1:WIDTH];
    assign mcand_ext = {mcand[WIDTH-1], mcand};  // sign extend

    // add/sub unit
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_res = upper + mcand_ext;
            ALU_SUB: alu_res = upper - mcand_ext;
            default: alu_res = upper;
        endcase
    end

    // multiplicand, only written on load
    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            mcand <= a;
        end
    end

    // product register and extra booth bit
    always_ff @(posedge clk) begin
        if (rst) begin
            prod      <= '0;
            extra_bit <= 1'b0;
        end else if (ctrl.load) begin
            prod      <= {{(WIDTH+1){1'b0}}, b};
            extra_bit <= 1'b0;
        end else if (ctrl.add_en) begin
            prod[PROD_W-1:WIDTH] <= alu_res;
        end else if (ctrl.shift_en) begin
            prod      <= {prod[PROD_W-1], prod[PROD_W-1:1]};  // asr by one
            extra_bit <= prod[0];
        end
    end

    // pair for the controller's decode
    assign ctrl.booth_pair = {prod[0], extra_bit};

    // guard bit dropped, the true product always fits in 2*WIDTH
    assign p = prod[2*WIDTH-1:0];

endmodule : booth_datapath

// ==== hdl/booth_ctrl.sv ====
`timescale 1ns/1ps

`include "mult_config.svh"

module booth_ctrl
    import mult_pkg::*;
#(
    parameter int WIDTH = `MULT_WIDTH
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    output logic    busy,
    output logic    done,
    mult_ctrl_if.ctrl ctrl
);

    localparam int             CNT_W     = $clog2(WIDTH);
    localparam logic [CNT_W-1:0] LAST_ITER = CNT_W'(WIDTH - 1);

    mult_state_e      state;
    mult_state_e      next_state;
    logic [CNT_W-1:0] iter_cnt;   // completed add/shift pairs
    alu_op_e          op_dec;

    // state register
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // iteration counter, advances once per shift
    always_ff @(posedge clk) begin
        if (rst) begin
            iter_cnt <= '0;
        end else if (state == LOAD) begin
            iter_cnt <= '0;
        end else if (state == SHIFT) begin
            iter_cnt <= iter_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = LOAD;
                end
            end
            LOAD:  next_state = ADD;
            ADD:   next_state = SHIFT;
            SHIFT: begin
                if (iter_cnt == LAST_ITER) begin
                    next_state = DONE;
                end else begin
                    next_state = ADD;
                end
            end
            DONE: begin
                // start in the done cycle chains the next operation
                if (start) begin
                    next_state = LOAD;
                end else begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // booth pair decode
    always_comb begin
        case (ctrl.booth_pair)
            2'b01:   op_dec = ALU_ADD;
            2'b10:   op_dec = ALU_SUB;
            default: op_dec = ALU_NONE;  // 00 / 11, shift only
        endcase
    end

    assign ctrl.load     = (state == LOAD);
    assign ctrl.alu_op   = (state == ADD) ? op_dec : ALU_NONE;
    assign ctrl.add_en   = (state == ADD) && (op_dec != ALU_NONE);
    assign ctrl.shift_en = (state == SHIFT);

    assign busy = (state != IDLE);
    assign done = (state == DONE);  // single cycle, DONE never repeats

endmodule : booth_ctrl

// ==== hdl/booth_mult.sv ====
`timescale 1ns/1ps

`include "mult_config.svh"

module booth_mult #(
    parameter int WIDTH = `MULT_WIDTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic signed [WIDTH-1:0]   a,
    input  logic signed [WIDTH-1:0]   b,
    output logic signed [2*WIDTH-1:0] p,
    output logic                      busy,
    output logic                      done
);

    // strobes down, booth pair up
    mult_ctrl_if ctrl_bus ();

    booth_ctrl #(
        .WIDTH (WIDTH)
    ) i_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done),
        .ctrl  (ctrl_bus.ctrl)
    );

    booth_datapath #(
        .WIDTH (WIDTH)
    ) i_dp (
        .clk  (clk),
        .rst  (rst),
        .a    (a),
        .b    (b),
        .p    (p),
        .ctrl (ctrl_bus.dp)
    );

endmodule : booth_mult

// ==== dv/booth_mult_assert.sv ====
`timescale 1ns/1ps

`include "mult_config.svh"

module booth_mult_assert
    import mult_pkg::*;
#(
    parameter int WIDTH = `MULT_WIDTH
) (
    input logic        clk,
    input logic        rst,
    input logic        start,
    input logic        busy,
    input logic        done,
    input mult_state_e state
);

    // start edge to the edge that samples done
    localparam int LATENCY = 2 * WIDTH + 2;

    logic accepted;

    // the done cycle also takes a new start
    assign accepted = start && (!busy || done);

    property done_single_p;
        @(posedge clk) disable iff (rst) done |=> !done;
    endproperty

    property done_busy_p;
        @(posedge clk) disable iff (rst) done |-> busy;
    endproperty

    property reset_idle_p;
        @(posedge clk) rst |=> (!done && !busy && state == IDLE);
    endproperty

    property latency_p;
        @(posedge clk) disable iff (rst)
            accepted |-> ##1 (!done) [*(LATENCY-1)] ##1 done;
    endproperty

    done_single_a: assert property (done_single_p)
        else $error("done high on two consecutive cycles");
    done_busy_a: assert property (done_busy_p)
        else $error("done without busy");
    reset_idle_a: assert property (reset_idle_p)
        else $error("controller not idle after reset");
    latency_a: assert property (latency_p)
        else $error("done not at the fixed latency after start");

endmodule : booth_mult_assert

bind booth_mult booth_mult_assert #(
    .WIDTH (WIDTH)
) i_assert (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .busy  (busy),
    .done  (done),
    .state (i_ctrl.state)
);

// ==== dv/booth_mult_tb.sv ====
`timescale 1ns/1ps

`include "mult_config.svh"

module booth_mult_tb;

    localparam int W          = `MULT_WIDTH;
    localparam int HALF       = `MULT_CLK_PERIOD / 2;
    localparam int SKEW       = `MULT_DRIVE_SKEW;
    localparam int DONE_EDGES = 2 * W + 1;  // start edge to done visible
    localparam int NUM_OPS    = `MULT_NUM_RANDOM + 16;  // corners and protocol runs
    localparam int MAX_CYCLES = (NUM_OPS + 10) * (2 * W + 4);

    typedef logic signed [W-1:0]   op_t;
    typedef logic signed [2*W-1:0] prod_t;

    localparam op_t OP_MIN = {1'b1, {(W-1){1'b0}}};
    localparam op_t OP_MAX = {1'b0, {(W-1){1'b1}}};

    logic   clk;
    logic   rst;
    logic   start;
    op_t    a;
    op_t    b;
    prod_t  p;
    logic   busy;
    logic   done;

    integer seed = `MULT_SEED;
    int     cycle_cnt = 0;

    initial begin
        clk = 1'b0;
        forever #(HALF) clk = ~clk;
    end

    booth_mult #(
        .WIDTH (W)
    ) i_dut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .a     (a),
        .b     (b),
        .p     (p),
        .busy  (busy),
        .done  (done)
    );

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_product(input string name, input prod_t exp, input prod_t act);
        if (act !== exp) begin
            fail_stop($sformatf("ERROR t=%0t %s expected %0d actual %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("ERROR t=%0t %s expected %b actual %b",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            fail_stop($sformatf("ERROR t=%0t done latency expected %0d actual %0d",
                                $time, exp, act));
        end
    endtask

    // all driving and sampling sits just after the rising edge
    task automatic wait_posedge();
        @(posedge clk);
        #(SKEW);
    endtask

    function automatic op_t rand_operand();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[W-1:0];
    endfunction

    // native signed product at full width
    function automatic prod_t model_product(input op_t x, input op_t y);
        prod_t ext_x;
        prod_t ext_y;
        ext_x = x;
        ext_y = y;
        return ext_x * ext_y;
    endfunction

    task automatic launch(input op_t op_a, input op_t op_b);
        start = 1'b1;
        a     = op_a;
        b     = op_b;
        wait_posedge();
        start = 1'b0;
    endtask

    // edges counted from the start edge, busy must stay high meanwhile
    task automatic wait_done(input int first, output int edges);
        edges = first;
        while (done !== 1'b1) begin
            check_flag("busy", 1'b1, busy);
            wait_posedge();
            edges++;
            if (edges > DONE_EDGES + 4) begin
                fail_stop("done never arrived after an accepted start");
            end
        end
    endtask

    task automatic finish_op(input prod_t expected, input int first);
        int edges;
        wait_done(first, edges);
        check_latency(DONE_EDGES, edges);
        check_flag("busy", 1'b1, busy);
        check_product("p", expected, p);
    endtask

    task automatic idle_check(input prod_t expected);
        wait_posedge();
        check_flag("done", 1'b0, done);
        check_flag("busy", 1'b0, busy);
        check_product("p", expected, p);
    endtask

    task automatic run_op(input op_t op_a, input op_t op_b);
        prod_t expected;
        expected = model_product(op_a, op_b);
        launch(op_a, op_b);
        finish_op(expected, 0);
        idle_check(expected);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_stop("timeout, the run went past its cycle limit");
        end
    end

    initial begin
        prod_t expected;
        op_t   xa;
        op_t   xb;
        op_t   ya;
        op_t   yb;

        rst   = 1'b1;
        start = 1'b0;
        a     = '0;
        b     = '0;
        repeat (`MULT_RST_CYCLES) @(posedge clk);
        #(SKEW);
        rst = 1'b0;

        check_flag("busy", 1'b0, busy);
        check_flag("done", 1'b0, done);
        check_product("p", '0, p);

        // corner operands
        run_op('0, OP_MAX);
        run_op(OP_MIN, '0);
        run_op(op_t'(1), OP_MIN);
        run_op(op_t'(-1), OP_MAX);
        run_op(OP_MIN, OP_MIN);
        run_op(OP_MIN, op_t'(-1));
        run_op(OP_MAX, OP_MIN);
        run_op(op_t'(-1), op_t'(-1));

        for (int i = 0; i < `MULT_NUM_RANDOM; i++) begin
            xa = rand_operand();
            xb = rand_operand();
            run_op(xa, xb);
        end

        // start while busy must be ignored
        xa = rand_operand();
        xb = rand_operand();
        ya = rand_operand();
        yb = rand_operand();
        expected = model_product(xa, xb);
        launch(xa, xb);
        repeat (10) wait_posedge();
        start = 1'b1;
        a     = ya;
        b     = yb;
        wait_posedge();
        start = 1'b0;
        finish_op(expected, 11);
        for (int i = 0; i < 8; i++) begin
            wait_posedge();
            check_flag("busy", 1'b0, busy);
            check_product("p", expected, p);
            a = rand_operand();  // p must not follow the inputs
            b = rand_operand();
        end

        // back to back, next start in the done cycle
        xa = rand_operand();
        xb = rand_operand();
        launch(xa, xb);
        for (int i = 0; i < 4; i++) begin
            expected = model_product(xa, xb);
            finish_op(expected, 0);
            if (i < 3) begin
                xa = rand_operand();
                xb = rand_operand();
                launch(xa, xb);
            end
        end
        idle_check(expected);

        // reset in the middle of a run
        xa = rand_operand();
        xb = rand_operand();
        launch(xa, xb);
        repeat (20) wait_posedge();
        rst = 1'b1;
        repeat (2) begin
            wait_posedge();
            check_flag("busy", 1'b0, busy);
            check_flag("done", 1'b0, done);
        end
        rst = 1'b0;
        check_product("p", '0, p);
        repeat (DONE_EDGES + 2) begin
            wait_posedge();
            check_flag("done", 1'b0, done);
            check_flag("busy", 1'b0, busy);
        end
        xa = rand_operand();
        xb = rand_operand();
        run_op(xa, xb);

        $display("All tests passed");
        $finish;
    end

endmodule : booth_mult_tb

// ==== booth_mult.f ====
+incdir+hdl
hdl/mult_pkg.sv
hdl/mult_ctrl_if.sv
hdl/booth_datapath.sv
hdl/booth_ctrl.sv
hdl/booth_mult.sv
dv/booth_mult_assert.sv
dv/booth_mult_tb.sv
